/* tests/draw_patterns.txt */
// op arg1 arg2 arg3 arg4 arg5 test, op and args in hex, test number in decimal
// op 1 window, 2 point, 3 hline, 4 vline, 6 rect; unused args are 0
1 0010 0020 0030 0040 0000 1
1 0000 00ef 0000 013f 0000 2
2 0005 0007 f800 0000 0000 3
2 0000 0000 0000 0000 0000 4
3 0010 0020 0005 0000 07e0 5
4 0010 0020 0005 0000 001f 6
3 0030 0040 0001 0000 aaaa 7
4 0030 0040 0001 0000 5555 8
6 0002 0003 0004 0004 ffff 9
6 0008 0001 0008 0004 1234 10
6 0001 0009 0005 0009 abcd 11
6 0064 0032 0064 0032 8410 12
6 0010 0010 0013 0013 c618 13
3 00e0 0100 0008 0000 f81f 14
4 0100 00e0 0008 0000 07ff 15
1 0001 0001 0002 0002 0000 16
2 00ef 013f 001f 0000 0000 17
6 0020 0030 0021 0032 3333 18

/* files.f */
rtl/tft_pkg.sv
rtl/fill_counter.sv
rtl/bus_writer.sv
rtl/draw_sequencer.sv
rtl/tft_draw_ctrl.sv
tests/tb_bus_assert.sv
tests/tb_bus_checker.sv
tests/tb_tft_draw.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the TFT draw controller testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_tft_draw -f files.f

./obj_dir/Vtb_tft_draw | tee sim.log

if grep -qx "Done: no errors" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

/* tests/tb_tft_draw.sv */
`timescale 1ns/1ps

module tb_tft_draw
	import tft_pkg::*;
();

	logic clk = 1'b0;
	logic rst_n;
	logic start;
	draw_op_t op;
	coord_t arg1;
	coord_t arg2;
	coord_t arg3;
	coord_t arg4;
	coord_t arg5;
	logic done;
	logic busy;
	logic lcd_cs;
	logic lcd_rs;
	logic lcd_wr;
	bus_word_t lcd_data;

	logic [3:0] pat_op[$]; // Pattern table, one entry per line.
	coord_t pat_a1[$];
	coord_t pat_a2[$];
	coord_t pat_a3[$];
	coord_t pat_a4[$];
	coord_t pat_a5[$];
	int pat_num[$];
	logic load_ok;
	int cur_test; // Test number shown to the checker.
	int chk_errors;
	int chk_tests;
	int cycles = 0;
	int cycle_limit = 0; // Set once the patterns are known.

	always #50 clk = ~clk; // 100 ns period.

	tft_draw_ctrl DUT (
		.clk (clk),
		.rst_n (rst_n),
		.start (start),
		.op (op),
		.arg1 (arg1),
		.arg2 (arg2),
		.arg3 (arg3),
		.arg4 (arg4),
		.arg5 (arg5),
		.done (done),
		.busy (busy),
		.lcd_cs (lcd_cs),
		.lcd_rs (lcd_rs),
		.lcd_wr (lcd_wr),
		.lcd_data (lcd_data)
	);

	tb_bus_checker u_checker (
		.clk (clk),
		.rst_n (rst_n),
		.start (start),
		.op (op),
		.arg1 (arg1),
		.arg2 (arg2),
		.arg3 (arg3),
		.arg4 (arg4),
		.arg5 (arg5),
		.done (done),
		.busy (busy),
		.lcd_cs (lcd_cs),
		.lcd_rs (lcd_rs),
		.lcd_wr (lcd_wr),
		.lcd_data (lcd_data),
		.test_num (cur_test),
		.error_count (chk_errors),
		.tests_checked (chk_tests)
	);

	bind bus_writer tb_bus_assert u_bus_assert (
		.clk (clk),
		.rst_n (rst_n),
		.lcd_cs (lcd_cs),
		.lcd_wr (lcd_wr),
		.lcd_rs (lcd_rs),
		.lcd_data (lcd_data),
		.word_done (word_done)
	);

	////////////////////////////////////////////////////////////////////////////
	// Pattern file and run length
	////////////////////////////////////////////////////////////////////////////
	function automatic int pixel_count(input logic [3:0] code, input coord_t a1,
			input coord_t a2, input coord_t a3, input coord_t a4);
		case (code)
			OP_POINT: return 1;
			OP_HLINE, OP_VLINE: return int'(a3); // Length operand.
			OP_RECT: return (int'(a3) - int'(a1) + 1) * (int'(a4) - int'(a2) + 1);
			default: return 0; // Window writes no colour.
		endcase
	endfunction

	task automatic load_patterns();
		int fd;
		string line;
		logic [15:0] code;
		logic [15:0] a1;
		logic [15:0] a2;
		logic [15:0] a3;
		logic [15:0] a4;
		logic [15:0] a5;
		int num;
		fd = $fopen("tests/draw_patterns.txt", "r");
		load_ok = (fd != 0);
		if (!load_ok) begin
			$display("Cannot open pattern file tests/draw_patterns.txt");
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0 &&
						$sscanf(line, "%h %h %h %h %h %h %d",
							code, a1, a2, a3, a4, a5, num) == 7) begin
					pat_op.push_back(code[3:0]); // Comment lines fail the scan.
					pat_a1.push_back(a1);
					pat_a2.push_back(a2);
					pat_a3.push_back(a3);
					pat_a4.push_back(a4);
					pat_a5.push_back(a5);
					pat_num.push_back(num);
				end
			end
			$fclose(fd);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////
	task automatic run_test(input int idx);
		@(posedge clk);
		start <= 1'b1;
		op <= draw_op_t'(pat_op[idx]);
		arg1 <= pat_a1[idx];
		arg2 <= pat_a2[idx];
		arg3 <= pat_a3[idx];
		arg4 <= pat_a4[idx];
		arg5 <= pat_a5[idx];
		cur_test <= pat_num[idx];
		@(posedge clk);
		start <= 1'b0;
		if (idx % 2 == 1) begin
			repeat (2) @(posedge clk);
			start <= 1'b1; // Request while busy, must be dropped.
			op <= OP_RECT;
			arg1 <= pat_a1[idx] + 16'd3;
			arg2 <= pat_a2[idx] + 16'd5;
			arg3 <= pat_a3[idx] + 16'd9;
			arg4 <= pat_a4[idx] + 16'd7;
			arg5 <= ~pat_a5[idx];
			@(posedge clk);
			start <= 1'b0;
		end
		@(posedge clk);
		while (done !== 1'b1)
			@(posedge clk); // Wait for the end pulse.
		@(posedge clk); // Idle gap between operations.
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		int total_words;
		int i;
		total_words = 0;
		rst_n <= 1'b0;
		start <= 1'b0;
		op <= OP_WINDOW;
		arg1 <= '0;
		arg2 <= '0;
		arg3 <= '0;
		arg4 <= '0;
		arg5 <= '0;
		cur_test <= 0;
		load_patterns();
		for (i = 0; i < pat_op.size(); i++)
			total_words += 7 + pixel_count(pat_op[i], pat_a1[i], pat_a2[i], pat_a3[i], pat_a4[i]);
		// Each word also pays a handshake turnaround, so twice a write.
		cycle_limit = total_words * 2 * WORD_CYCLES + 20 * pat_op.size() + 100;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		if (load_ok) begin
			for (i = 0; i < pat_op.size(); i++)
				run_test(i);
		end
		repeat (4) @(posedge clk);
		if (chk_tests != pat_op.size())
			$display("Operation count wrong: %0d done pulses checked, %0d patterns sent",
				chk_tests, pat_op.size());
		$display("Summary: %0d patterns, %0d operations checked, %0d errors, %0d assert fails",
			pat_op.size(), chk_tests, chk_errors, DUT.u_wr.u_bus_assert.fail_count);
		if (!load_ok || pat_op.size() == 0 || chk_tests != pat_op.size() || chk_errors != 0 ||
				DUT.u_wr.u_bus_assert.fail_count != 0)
			$display("Done: errors found");
		else
			$display("Done: no errors");
		$finish;
	end

endmodule

/* tests/tb_bus_checker.sv */
`timescale 1ns/1ps

module tb_bus_checker
	import tft_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input draw_op_t op,
	input coord_t arg1,
	input coord_t arg2,
	input coord_t arg3,
	input coord_t arg4,
	input coord_t arg5,
	input logic done,
	input logic busy,
	input logic lcd_cs,
	input logic lcd_rs,
	input logic lcd_wr,
	input bus_word_t lcd_data,
	input int test_num, // Current pattern number.
	output int error_count,
	output int tests_checked
);

	bus_word_t exp_word[$]; // Words still owed by the DUT.
	logic exp_rs[$];
	int errors = 0;
	int checked = 0;
	int test_errors = 0;
	int test_id = 0;
	int word_idx = 0; // Words seen in this operation.
	draw_op_t cur_op = OP_WINDOW;
	logic active = 1'b0; // Operation accepted, done not yet seen.
	logic prev_wr = 1'b1;
	logic prev_done = 1'b0;
	logic prev_accept = 1'b0;

	assign error_count = errors;
	assign tests_checked = checked;

	task automatic report_mismatch(input string sig, input logic [15:0] expected,
			input logic [15:0] actual);
		$display("CHECK FAILED test %0d word %0d: %s expected 0x%h, got 0x%h",
			test_id, word_idx, sig, expected, actual);
		errors++;
		test_errors++;
	endtask

	task automatic report_problem(input string what);
		$display("Test %0d: %s", test_id, what);
		errors++;
		test_errors++;
	endtask

	task automatic push_word(input bus_word_t w, input logic rs);
		exp_word.push_back(w);
		exp_rs.push_back(rs);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Expected word stream for one operation
	////////////////////////////////////////////////////////////////////////////
	task automatic expand_op(input draw_op_t code, input coord_t a1, input coord_t a2,
			input coord_t a3, input coord_t a4, input coord_t a5);
		coord_t c0;
		coord_t c1;
		coord_t r0;
		coord_t r1;
		color_t colour;
		int npix;
		int i;
		c0 = a1; // Every op starts at column arg1.
		c1 = a1;
		r0 = a2;
		r1 = a2;
		colour = a5;
		npix = 0;
		case (code)
			OP_WINDOW: begin
				c1 = a2;
				r0 = a3; // Rows come from arg3 and arg4 here.
				r1 = a4;
			end
			OP_POINT: begin
				npix = 1;
				colour = a3; // Point colour is arg3.
			end
			OP_HLINE: begin
				c1 = a1 + a3 - 16'd1;
				npix = int'(a3);
			end
			OP_VLINE: begin
				r1 = a2 + a3 - 16'd1;
				npix = int'(a3);
			end
			OP_RECT: begin
				c1 = a3;
				r1 = a4;
				npix = (int'(a3) - int'(a1) + 1) * (int'(a4) - int'(a2) + 1);
			end
			default: report_problem("unknown operation code accepted");
		endcase
		push_word(CMD_CASET, 1'b0);
		push_word(c0, 1'b1);
		push_word(c1, 1'b1);
		push_word(CMD_RASET, 1'b0);
		push_word(r0, 1'b1);
		push_word(r1, 1'b1);
		push_word(CMD_RAMWR, 1'b0);
		for (i = 0; i < npix; i++)
			push_word(colour, 1'b1);
	endtask

	task automatic close_test();
		if (exp_word.size() != 0)
			report_problem($sformatf("%0d expected words never reached the bus", exp_word.size()));
		if (test_errors == 0)
			$display("Test %0d (op %0d): %0d words, ok", test_id, int'(cur_op), word_idx);
		else
			$display("Test %0d (op %0d): %0d words, %0d errors",
				test_id, int'(cur_op), word_idx, test_errors);
		active = 1'b0;
		checked++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus monitor
	////////////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		bus_word_t ew;
		logic er;
		if (!rst_n) begin
			prev_wr = 1'b1;
			prev_done = 1'b0;
			prev_accept = 1'b0;
		end else begin
			if (done) begin
				if (prev_done)
					report_problem("done stayed high for more than one cycle");
				else if (!active)
					report_problem("done pulsed with no operation running");
				else
					close_test();
				if (busy)
					report_problem("busy still high while done pulses");
			end
			if (prev_accept && !busy)
				report_problem("busy did not rise after start");
			if (!busy && lcd_cs !== 1'b1)
				report_problem("CS low while no operation is running");
			if (!busy && lcd_wr !== 1'b1)
				report_problem("WR low while no operation is running");
			if (start && !busy) begin
				if (active)
					report_problem("new operation accepted before done");
				exp_word.delete();
				exp_rs.delete();
				test_id = test_num;
				test_errors = 0;
				word_idx = 0;
				cur_op = op;
				expand_op(op, arg1, arg2, arg3, arg4, arg5); // Operands as captured.
				active = 1'b1;
			end
			if (!prev_wr && lcd_wr) begin // WR rising edge, panel latch.
				if (exp_word.size() == 0) begin
					report_problem($sformatf("extra word 0x%h on the bus", lcd_data));
				end else begin
					ew = exp_word.pop_front();
					er = exp_rs.pop_front();
					if (lcd_data !== ew)
						report_mismatch("lcd_data", ew, lcd_data);
					if (lcd_rs !== er)
						report_mismatch("lcd_rs", 16'(er), 16'(lcd_rs));
				end
				word_idx++;
			end
			prev_wr = lcd_wr;
			prev_done = done;
			prev_accept = start && !busy;
		end
	end

endmodule

/* tests/tb_bus_assert.sv */
`timescale 1ns/1ps

module tb_bus_assert
	import tft_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic lcd_cs,
	input logic lcd_wr,
	input logic lcd_rs,
	input bus_word_t lcd_data,
	input logic word_done
);

	int fail_count = 0; // Failed assertion evaluations.

	// Write strobes only inside a chip select window.
	wr_inside_cs: assert property (@(posedge clk) disable iff (!rst_n)
		!lcd_wr |-> !lcd_cs)
		else begin
			$error("WR low while CS is high");
			fail_count++;
		end

	// Panel sees settled data up to the latch edge.
	data_held_low: assert property (@(posedge clk) disable iff (!rst_n)
		(!lcd_wr && $past(!lcd_wr)) |-> ($stable(lcd_data) && $stable(lcd_rs)))
		else begin
			$error("DATA or RS changed while WR low");
			fail_count++;
		end

	done_in_high: assert property (@(posedge clk) disable iff (!rst_n)
		word_done |-> lcd_wr)
		else begin
			$error("word_done outside the WR high phase");
			fail_count++;
		end

endmodule

/* rtl/tft_draw_ctrl.sv */
`timescale 1ns/1ps

module tft_draw_ctrl
	import tft_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start, // One-cycle request.
	input draw_op_t op, // Operation code.
	input coord_t arg1,
	input coord_t arg2,
	input coord_t arg3,
	input coord_t arg4,
	input coord_t arg5,
	output logic done, // One-cycle end pulse.
	output logic busy, // Operation in progress.
	output logic lcd_cs,
	output logic lcd_rs,
	output logic lcd_wr,
	output bus_word_t lcd_data
);

	logic word_strobe; // Sequencer to writer request.
	bus_word_t word;
	logic is_data;
	logic word_done; // Writer finished the word.
	logic load; // Counter setup.
	coord_t width;
	coord_t height;
	logic step; // One pixel written.
	logic last; // Final pixel flag.

	draw_sequencer u_seq (
		.clk (clk),
		.rst_n (rst_n),
		.start (start),
		.op (op),
		.arg1 (arg1),
		.arg2 (arg2),
		.arg3 (arg3),
		.arg4 (arg4),
		.arg5 (arg5),
		.word_strobe (word_strobe),
		.word (word),
		.is_data (is_data),
		.word_done (word_done),
		.load (load),
		.width (width),
		.height (height),
		.step (step),
		.last (last),
		.done (done),
		.busy (busy)
	);

	fill_counter u_cnt (
		.clk (clk),
		.rst_n (rst_n),
		.load (load),
		.width (width),
		.height (height),
		.step (step),
		.last (last)
	);

	bus_writer u_wr (
		.clk (clk),
		.rst_n (rst_n),
		.word_strobe (word_strobe),
		.word (word),
		.is_data (is_data),
		.word_done (word_done),
		.busy (busy),
		.lcd_cs (lcd_cs),
		.lcd_rs (lcd_rs),
		.lcd_wr (lcd_wr),
		.lcd_data (lcd_data)
	);

endmodule

/* rtl/draw_sequencer.sv */
`timescale 1ns/1ps

module draw_sequencer
	import tft_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start, // Host request.
	input draw_op_t op,
	input coord_t arg1,
	input coord_t arg2,
	input coord_t arg3,
	input coord_t arg4,
	input coord_t arg5,
	output logic word_strobe, // Send word to the writer.
	output bus_word_t word,
	output logic is_data, // RS level for this word.
	input logic word_done, // Writer finished.
	output logic load, // Start pixel walk.
	output coord_t width,
	output coord_t height,
	output logic step, // Pixel written.
	input logic last, // Current pixel is the final one.
	output logic done, // End of operation.
	output logic busy
);

	seq_state_t state;
	seq_state_t next_hdr; // Following header slot.
	logic pending; // Word strobed, waiting for done.
	logic accept; // Start taken this cycle.

	coord_t col_start;
	coord_t col_end;
	coord_t row_start;
	coord_t row_end;
	color_t color_r;
	logic has_pixels; // Window op writes no colour.

	assign accept = start && (state == S_IDLE); // Start ignored while busy.
	assign busy = (state != S_IDLE);

	// Window size for the pixel counter.
	assign width = col_end - col_start + 16'd1;
	assign height = row_end - row_start + 16'd1;

	////////////////////////////////////////////////////////////////////////////
	// Operand capture
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (accept) begin
			case (op)
				OP_POINT: begin
					col_start <= arg1; // Single column.
					col_end <= arg1;
					row_start <= arg2; // Single row.
					row_end <= arg2;
					color_r <= arg3;
					has_pixels <= 1'b1;
				end
				OP_HLINE: begin
					col_start <= arg1;
					col_end <= arg1 + arg3 - 16'd1; // Length arg3.
					row_start <= arg2;
					row_end <= arg2;
					color_r <= arg5;
					has_pixels <= 1'b1;
				end
				OP_VLINE: begin
					col_start <= arg1;
					col_end <= arg1;
					row_start <= arg2;
					row_end <= arg2 + arg3 - 16'd1; // Length arg3.
					color_r <= arg5;
					has_pixels <= 1'b1;
				end
				OP_RECT: begin
					col_start <= arg1; // Corners given directly.
					col_end <= arg3;
					row_start <= arg2;
					row_end <= arg4;
					color_r <= arg5;
					has_pixels <= 1'b1;
				end
				default: begin
					// Window and unknown codes: address only.
					col_start <= arg1;
					col_end <= arg2;
					row_start <= arg3;
					row_end <= arg4;
					color_r <= arg5;
					has_pixels <= 1'b0;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Word select
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		word = '0;
		is_data = 1'b0; // Commands go out with RS low.
		next_hdr = S_IDLE;
		case (state)
			S_CASET: begin
				word = CMD_CASET;
				next_hdr = S_COL_START;
			end
			S_COL_START: begin
				word = col_start;
				is_data = 1'b1;
				next_hdr = S_COL_END;
			end
			S_COL_END: begin
				word = col_end;
				is_data = 1'b1;
				next_hdr = S_RASET;
			end
			S_RASET: begin
				word = CMD_RASET;
				next_hdr = S_ROW_START;
			end
			S_ROW_START: begin
				word = row_start;
				is_data = 1'b1;
				next_hdr = S_ROW_END;
			end
			S_ROW_END: begin
				word = row_end;
				is_data = 1'b1;
				next_hdr = S_RAMWR;
			end
			S_RAMWR: begin
				word = CMD_RAMWR;
				next_hdr = S_PIXEL;
			end
			S_PIXEL: begin
				word = color_r; // Same colour for every pixel.
				is_data = 1'b1;
				next_hdr = S_PIXEL;
			end
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequencer FSM
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			pending <= 1'b0;
			word_strobe <= 1'b0;
			load <= 1'b0;
			step <= 1'b0;
			done <= 1'b0;
		end else begin
			word_strobe <= 1'b0; // All pulses one cycle.
			load <= 1'b0;
			step <= 1'b0;
			done <= 1'b0;
			if (state == S_IDLE) begin
				if (accept)
					state <= S_CASET;
			end else if (!pending) begin
				word_strobe <= 1'b1; // Writer is idle here.
				pending <= 1'b1;
			end else if (word_done) begin
				pending <= 1'b0;
				if (state == S_PIXEL) begin
					step <= 1'b1; // Advance pixel counter.
					if (last) begin
						state <= S_IDLE;
						done <= 1'b1;
					end
				end else if (state == S_RAMWR && !has_pixels) begin
					state <= S_IDLE; // Window op ends after RAMWR.
					done <= 1'b1;
				end else begin
					if (state == S_RAMWR)
						load <= 1'b1; // Arm counter for the fill.
					state <= next_hdr;
				end
			end
		end
	end

endmodule

/* rtl/bus_writer.sv */
`timescale 1ns/1ps

module bus_writer
	import tft_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic word_strobe, // Start one write.
	input bus_word_t word,
	input logic is_data, // RS level.
	output logic word_done, // Last high cycle.
	input logic busy, // Operation in progress.
	output logic lcd_cs,
	output logic lcd_rs,
	output logic lcd_wr,
	output bus_word_t lcd_data
);

	logic active; // Write cycle running.
	logic [PHASE_W-1:0] phase; // Clock within the write.

	// Chip select spans the whole operation.
	assign lcd_cs = ~busy;

	////////////////////////////////////////////////////////////////////////////
	// 8080 write cycle
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			phase <= '0;
			word_done <= 1'b0;
			lcd_wr <= 1'b1; // Idle high.
			lcd_rs <= 1'b1;
			lcd_data <= '0;
		end else begin
			word_done <= 1'b0;
			if (!active) begin
				if (word_strobe) begin
					active <= 1'b1;
					phase <= '0;
					lcd_wr <= 1'b0; // Low phase begins.
					lcd_rs <= is_data;
					lcd_data <= word; // Held until next strobe.
				end
			end else begin
				phase <= phase + 1'b1;
				if (phase == PHASE_W'(WR_LOW_CYCLES - 1))
					lcd_wr <= 1'b1; // Rising edge latches data.
				if (phase == PHASE_W'(WORD_CYCLES - 2))
					word_done <= 1'b1; // Lands on last high cycle.
				if (phase == PHASE_W'(WORD_CYCLES - 1))
					active <= 1'b0;
			end
		end
	end

endmodule

/* rtl/fill_counter.sv */
`timescale 1ns/1ps

module fill_counter
	import tft_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic load, // New area.
	input coord_t width, // Columns in area.
	input coord_t height, // Rows in area.
	input logic step, // One pixel done.
	output logic last // On final pixel.
);

	coord_t col; // Column within area.
	coord_t row; // Row within area.
	coord_t col_max; // Width minus one.
	coord_t row_max; // Height minus one.

	// Area limits, held for the whole fill.
	always_ff @(posedge clk) begin
		if (load) begin
			col_max <= width - 16'd1;
			row_max <= height - 16'd1;
		end
	end

	// Column runs first, row advances on wrap.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col <= '0;
			row <= '0;
		end else if (load) begin
			col <= '0;
			row <= '0;
		end else if (step) begin
			if (col == col_max) begin
				col <= '0; // End of row.
				row <= (row == row_max) ? '0 : row + 16'd1;
			end else begin
				col <= col + 16'd1;
			end
		end
	end

	assign last = (col == col_max) && (row == row_max); // Both on final values.

endmodule

/* rtl/tft_pkg.sv */
package tft_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data widths
	////////////////////////////////////////////////////////////////////////////
	typedef logic [15:0] coord_t; // Pixel coordinate or length.
	typedef logic [15:0] color_t; // RGB565 colour.
	typedef logic [15:0] bus_word_t; // Word on the panel data pins.

	// Host operation codes, same numbering as the panel driver.
	typedef enum logic [3:0] {
		OP_WINDOW = 4'd1, // Column/row window, then RAMWR.
		OP_POINT = 4'd2, // One pixel.
		OP_HLINE = 4'd3, // Horizontal run.
		OP_VLINE = 4'd4, // Vertical run.
		OP_RECT = 4'd6 // Filled box.
	} draw_op_t;

	// Sequencer states, one per bus word slot.
	typedef enum logic [3:0] {
		S_IDLE = 4'd0, // Waiting for start.
		S_CASET = 4'd1, // Column address command.
		S_COL_START = 4'd2, // First column.
		S_COL_END = 4'd3, // Last column.
		S_RASET = 4'd4, // Row address command.
		S_ROW_START = 4'd5, // First row.
		S_ROW_END = 4'd6, // Last row.
		S_RAMWR = 4'd7, // Memory write command.
		S_PIXEL = 4'd8 // Colour words.
	} seq_state_t;

	////////////////////////////////////////////////////////////////////////////
	// Panel commands and write timing
	////////////////////////////////////////////////////////////////////////////
	localparam bus_word_t CMD_CASET = 16'h002A; // Column address set.
	localparam bus_word_t CMD_RASET = 16'h002B; // Row address set.
	localparam bus_word_t CMD_RAMWR = 16'h002C; // Memory write.

	localparam int WR_LOW_CYCLES = 2; // WR low phase in clocks.
	localparam int WR_HIGH_CYCLES = 2; // WR high phase in clocks.
	localparam int WORD_CYCLES = WR_LOW_CYCLES + WR_HIGH_CYCLES; // One full write.
	localparam int PHASE_W = $clog2(WORD_CYCLES); // Phase counter width.

endpackage
